// ==== Makefile ====
SOURCES := $(wildcard hw/*.sv tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vburst_mem_tb: src.f $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module burst_mem_tb -f src.f

run: obj_dir/Vburst_mem_tb
	./obj_dir/Vburst_mem_tb | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/burst_mem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_mem_top (
	input  wire                  clk,
	input  wire                  reset,
	input  burst_pkg::host_req_t host_req,
	output logic                 host_waitrequest,
	output burst_pkg::rsp_t      host_rsp
);

	burst_pkg::mem_req_t mem_req;
	logic                mem_waitrequest;

	// Bursts are split into single word reads before they reach the memory.
	burst_splitter i_burst_splitter (
		.clk              (clk),
		.reset            (reset),
		.host_req         (host_req),
		.host_waitrequest (host_waitrequest),
		.mem_req          (mem_req),
		.mem_waitrequest  (mem_waitrequest)
	);

	// Read responses need no reordering, so they go straight back to the host.
	word_mem i_word_mem (
		.clk             (clk),
		.reset           (reset),
		.mem_req         (mem_req),
		.mem_waitrequest (mem_waitrequest),
		.mem_rsp         (host_rsp)
	);

endmodule

`default_nettype wire

// ==== hw/burst_pkg.sv ====
`default_nettype none

package burst_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  byteen_t;
	typedef logic [2:0]  burst_len_t;

	localparam addr_t WORD_BYTES     = 32'd4;
	localparam int    WORD_OFFSET    = $clog2(WORD_BYTES);
	localparam int    MEM_WORDS_LOG2 = 10;
	localparam int    READ_LATENCY   = 2;
	localparam int    STALL_PERIOD   = 4;

	// Index of one word inside the memory array.
	typedef logic [MEM_WORDS_LOG2-1:0] mem_index_t;

	// Free-running counter that paces the memory wait states.
	typedef logic [$clog2(STALL_PERIOD)-1:0] stall_cnt_t;
	localparam stall_cnt_t STALL_LAST = stall_cnt_t'(STALL_PERIOD - 1);

	// First beat of a split burst is the host cycle itself, so the counter restarts here.
	localparam burst_len_t BURST_FIRST_COUNT = 3'd2;

	typedef struct packed {
		logic       read;
		logic       write;
		addr_t      address;
		word_t      writedata;
		byteen_t    byteenable;
		logic       beginburst;
		burst_len_t burstcount;
	} host_req_t;

	typedef struct packed {
		logic    read;
		logic    write;
		addr_t   address;
		word_t   writedata;
		byteen_t byteenable;
	} mem_req_t;

	typedef struct packed {
		word_t readdata;
		logic  readdatavalid;
	} rsp_t;

endpackage

`default_nettype wire

// ==== hw/burst_splitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_splitter (
	input  wire                  clk,
	input  wire                  reset,
	input  burst_pkg::host_req_t host_req,
	output logic                 host_waitrequest,
	output burst_pkg::mem_req_t  mem_req,
	input  wire                  mem_waitrequest
);

	logic                  handling_burst;
	logic                  pending_burst;
	burst_pkg::burst_len_t burst_length;
	burst_pkg::burst_len_t next_burst_length;
	burst_pkg::burst_len_t burst_count;
	burst_pkg::addr_t      burst_address;

	logic                  host_active;
	logic                  host_accept;
	logic                  burst_start;
	logic                  beat_accept;
	logic                  last_beat;
	burst_pkg::burst_len_t start_length;

	assign host_active = host_req.read | host_req.write;

	// The host sees the memory's stall unless a burst owns the memory port.
	assign host_waitrequest = (host_active & ~handling_burst) ? mem_waitrequest : 1'b1;

	assign host_accept = ~host_waitrequest;

	// A fresh strobe carries its own count; otherwise the count was captured earlier.
	assign start_length = host_req.beginburst ? host_req.burstcount : next_burst_length;

	assign burst_start = host_accept & (pending_burst | host_req.beginburst);
	assign beat_accept = handling_burst & ~mem_waitrequest;
	assign last_beat   = beat_accept & (burst_count == burst_length);

	always_comb
	begin
		if (handling_burst)
		begin
			mem_req.read       = 1'b1;
			mem_req.write      = 1'b0;
			mem_req.address    = burst_address;
			mem_req.writedata  = host_req.writedata;
			mem_req.byteenable = '1;
		end
		else
		begin
			mem_req.read       = host_req.read;
			mem_req.write      = host_req.write;
			mem_req.address    = host_req.address;
			mem_req.writedata  = host_req.writedata;
			mem_req.byteenable = host_req.byteenable;
		end
	end

	// A single-word burst is finished by the host cycle alone.
	always_ff @(posedge clk)
	begin
		if (reset)
			handling_burst <= 1'b0;
		else if (burst_start & (start_length > 3'd1))
			handling_burst <= 1'b1;
		else if (last_beat)
			handling_burst <= 1'b0;
	end

	// Remembers a strobe that showed up while the port was stalled.
	always_ff @(posedge clk)
	begin
		if (reset)
			pending_burst <= 1'b0;
		else if (host_accept)
			pending_burst <= 1'b0;
		else if (host_active & host_req.beginburst)
			pending_burst <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			next_burst_length <= '0;
		else if (host_active & host_req.beginburst)
			next_burst_length <= host_req.burstcount;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			burst_length <= '0;
		else if (burst_start)
			burst_length <= start_length;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			burst_count <= '0;
		else if (burst_start)
			burst_count <= burst_pkg::BURST_FIRST_COUNT;
		else if (beat_accept)
			burst_count <= burst_count + 3'd1;
	end

	// Word following the host address is the first one issued by the splitter.
	always_ff @(posedge clk)
	begin
		if (reset)
			burst_address <= '0;
		else if (burst_start)
			burst_address <= host_req.address + burst_pkg::WORD_BYTES;
		else if (beat_accept)
			burst_address <= burst_address + burst_pkg::WORD_BYTES;
	end

endmodule

`default_nettype wire

// ==== hw/word_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_mem (
	input  wire                 clk,
	input  wire                 reset,
	input  burst_pkg::mem_req_t mem_req,
	output logic                mem_waitrequest,
	output burst_pkg::rsp_t     mem_rsp
);

	localparam int LAST_STAGE = burst_pkg::READ_LATENCY - 1;

	burst_pkg::word_t      mem [2**burst_pkg::MEM_WORDS_LOG2];
	burst_pkg::stall_cnt_t stall_cnt;
	burst_pkg::mem_index_t word_index;

	logic                  read_accept;
	logic                  write_accept;

	logic                  valid_pipe [burst_pkg::READ_LATENCY];
	burst_pkg::word_t      data_pipe  [burst_pkg::READ_LATENCY];

	// Byte offset bits are dropped. Upper address bits beyond the array wrap.
	assign word_index = mem_req.address[burst_pkg::WORD_OFFSET +: burst_pkg::MEM_WORDS_LOG2];

	// One stalled cycle in every STALL_PERIOD.
	assign mem_waitrequest = (stall_cnt == burst_pkg::STALL_LAST);

	assign read_accept  = mem_req.read & ~mem_waitrequest;
	assign write_accept = mem_req.write & ~mem_waitrequest;

	always_ff @(posedge clk)
	begin
		if (reset)
			stall_cnt <= '0;
		else if (stall_cnt == burst_pkg::STALL_LAST)
			stall_cnt <= '0;
		else
			stall_cnt <= stall_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (write_accept)
		begin
			for (int i = 0; i < burst_pkg::WORD_BYTES; i++)
			begin
				if (mem_req.byteenable[i])
					mem[word_index][8*i +: 8] <= mem_req.writedata[8*i +: 8];
			end
		end
	end

	// Valid flags walk the pipeline so that several reads can be outstanding.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < burst_pkg::READ_LATENCY; i++)
				valid_pipe[i] <= 1'b0;
		end
		else
		begin
			valid_pipe[0] <= read_accept;
			for (int i = 1; i < burst_pkg::READ_LATENCY; i++)
				valid_pipe[i] <= valid_pipe[i-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (read_accept)
			data_pipe[0] <= mem[word_index];
		for (int i = 1; i < burst_pkg::READ_LATENCY; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign mem_rsp.readdata      = data_pipe[LAST_STAGE];
	assign mem_rsp.readdatavalid = valid_pipe[LAST_STAGE];

endmodule

`default_nettype wire

// ==== src.f ====
hw/burst_pkg.sv
hw/burst_splitter.sv
hw/word_mem.sv
hw/burst_mem_top.sv
tb/burst_mem_chk.sv
tb/burst_mem_tb.sv

// ==== tb/burst_mem_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_mem_chk (
	input wire                  clk,
	input wire                  reset,
	input burst_pkg::host_req_t host_req,
	input wire                  host_waitrequest,
	input burst_pkg::rsp_t      host_rsp
);

	logic host_active;

	assign host_active = host_req.read | host_req.write;

	// A stalled request stays put until the port takes it.
	held_while_waiting: assert property (@(posedge clk) disable iff (reset)
		host_active && host_waitrequest |=> $stable(host_req))
		else $error("host request changed while waitrequest was high");

	// Bursts are reads only.
	burst_not_write: assert property (@(posedge clk) disable iff (reset)
		host_req.beginburst |-> !host_req.write)
		else $error("beginburst came together with a write");

	burst_count_nonzero: assert property (@(posedge clk) disable iff (reset)
		host_req.beginburst |-> host_req.burstcount != '0)
		else $error("beginburst came with a burst count of zero");

	// The read pipeline starts out empty.
	quiet_after_reset: assert property (@(posedge clk)
		!reset && ($past(reset) || $past(reset, 2)) |-> !host_rsp.readdatavalid)
		else $error("readdatavalid was high right after reset");

endmodule

bind burst_mem_top burst_mem_chk i_burst_mem_chk (
	.clk              (clk),
	.reset            (reset),
	.host_req         (host_req),
	.host_waitrequest (host_waitrequest),
	.host_rsp         (host_rsp)
);

`default_nettype wire

// ==== tb/burst_mem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_mem_tb;

	// The whole run needs well under a thousand cycles. The limit allows about four times that.
	localparam int               TIMEOUT_CYCLES = 4000;
	localparam logic [31:0]      SEED           = 32'h3bb6ac4b;
	localparam int               BYTE_OFFSET    = 2;
	localparam burst_pkg::addr_t BURST_BASE     = 32'h0000_0400;
	localparam burst_pkg::addr_t SCRATCH_BASE   = 32'h0000_0c00;

	logic                 clk;
	logic                 reset;
	burst_pkg::host_req_t host_req;
	logic                 host_waitrequest;
	burst_pkg::rsp_t      host_rsp;

	// Mirror of the memory as the testbench has written it.
	burst_pkg::word_t ref_mem [2**burst_pkg::MEM_WORDS_LOG2];
	burst_pkg::word_t exp_q [$];
	burst_pkg::word_t rsp_q [$];
	burst_pkg::addr_t addr_q [$];

	logic [31:0] seed            = SEED;
	int          words_requested = 0;
	int          rdv_count       = 0;
	int          cycle_count     = 0;
	int          last_waits      = 0;
	string       test_name       = "reset";

	burst_mem_top i_burst_mem_top (
		.clk              (clk),
		.reset            (reset),
		.host_req         (host_req),
		.host_waitrequest (host_waitrequest),
		.host_rsp         (host_rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(logic [31:0] value);
		logic [31:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		seed = xorshift32(seed);
		return seed;
	endfunction

	function automatic int word_slot(burst_pkg::addr_t addr);
		return int'(addr[BYTE_OFFSET +: burst_pkg::MEM_WORDS_LOG2]);
	endfunction

	function automatic burst_pkg::word_t merge_bytes(burst_pkg::word_t old_word,
			burst_pkg::word_t new_word, burst_pkg::byteen_t be);
		burst_pkg::word_t merged;
		merged = old_word;
		for (int i = 0; i < 4; i++)
		begin
			if (be[i])
				merged[8*i +: 8] = new_word[8*i +: 8];
		end
		return merged;
	endfunction

	task automatic fail_run(string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(burst_pkg::word_t expected, burst_pkg::word_t actual);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
				test_name, expected, actual));
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_run($sformatf("Timeout: the run did not finish within %0d cycles.",
				TIMEOUT_CYCLES));
	end

	// Responses are picked up mid-cycle, where the DUT outputs have settled.
	always @(negedge clk)
	begin
		if (!reset && host_rsp.readdatavalid)
		begin
			rsp_q.push_back(host_rsp.readdata);
			rdv_count++;
		end
	end

	task automatic drive_idle();
		host_req = '0;
	endtask

	// Returns just after the edge that took the request.
	task automatic wait_accept();
		last_waits = 0;
		@(negedge clk);
		while (host_waitrequest)
		begin
			last_waits++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic issue_write(burst_pkg::addr_t addr, burst_pkg::word_t data,
			burst_pkg::byteen_t be);
		host_req = '0;
		host_req.write = 1'b1;
		host_req.address = addr;
		host_req.writedata = data;
		host_req.byteenable = be;
		wait_accept();
		ref_mem[word_slot(addr)] = merge_bytes(ref_mem[word_slot(addr)], data, be);
	endtask

	task automatic issue_read(burst_pkg::addr_t addr);
		host_req = '0;
		host_req.read = 1'b1;
		host_req.address = addr;
		host_req.byteenable = '1;
		wait_accept();
		exp_q.push_back(ref_mem[word_slot(addr)]);
		words_requested++;
	endtask

	task automatic issue_burst(burst_pkg::addr_t addr, burst_pkg::burst_len_t count);
		host_req = '0;
		host_req.read = 1'b1;
		host_req.address = addr;
		host_req.byteenable = '1;
		host_req.beginburst = 1'b1;
		host_req.burstcount = count;
		wait_accept();
		for (int k = 0; k < int'(count); k++)
			exp_q.push_back(ref_mem[word_slot(addr + burst_pkg::WORD_BYTES * k)]);
		words_requested += int'(count);
	endtask

	// Waits in steps of whole cycles so that the next request starts just after a rising edge.
	task automatic drain_responses();
		burst_pkg::word_t want;
		burst_pkg::word_t got;
		while (exp_q.size() > 0)
		begin
			while (rsp_q.size() == 0)
			begin
				@(posedge clk);
				#1;
			end
			want = exp_q.pop_front();
			got = rsp_q.pop_front();
			check_value(want, got);
		end
	endtask

	task automatic host_write(burst_pkg::addr_t addr, burst_pkg::word_t data,
			burst_pkg::byteen_t be);
		issue_write(addr, data, be);
		drive_idle();
	endtask

	task automatic host_read(burst_pkg::addr_t addr);
		issue_read(addr);
		drive_idle();
		drain_responses();
	endtask

	task automatic host_burst(burst_pkg::addr_t addr, burst_pkg::burst_len_t count);
		issue_burst(addr, count);
		drive_idle();
		drain_responses();
	endtask

	// Back-to-back writes meet a stall within one period. The task returns two cycles after it.
	task automatic find_stall();
		int tries;
		tries = 0;
		last_waits = 0;
		while (last_waits == 0)
		begin
			if (tries > burst_pkg::STALL_PERIOD)
				fail_run("The memory never raised waitrequest during back-to-back writes.");
			else
			begin
				issue_write(SCRATCH_BASE + 4 * tries, next_random(), 4'hf);
				tries++;
			end
		end
		drive_idle();
	endtask

	task automatic run_single_rw();
		burst_pkg::addr_t addr;
		test_name = "single write and read";
		for (int i = 0; i < 12; i++)
		begin
			addr = next_random() & 32'h0000_0ffc;
			addr_q.push_back(addr);
			host_write(addr, next_random(), 4'hf);
		end
		foreach (addr_q[i])
			host_read(addr_q[i]);
	endtask

	task automatic run_partial_writes();
		logic [31:0] r;
		test_name = "partial write";
		foreach (addr_q[i])
		begin
			r = next_random();
			host_write(addr_q[i], next_random(), r[3:0]);
			host_read(addr_q[i]);
		end
	endtask

	task automatic run_burst_lengths();
		test_name = "burst fill";
		for (int i = 0; i < 48; i++)
			host_write(BURST_BASE + 4 * i, next_random(), 4'hf);
		for (int n = 1; n <= 7; n++)
		begin
			test_name = $sformatf("burst length %0d", n);
			host_burst(BURST_BASE + 4 * (n * 3), 3'(n));
		end
	endtask

	task automatic run_stalled_bursts();
		int lengths [3] = '{3, 5, 7};
		test_name = "stalled burst";
		foreach (lengths[i])
		begin
			find_stall();
			repeat (burst_pkg::STALL_PERIOD - 2) @(posedge clk);
			#1;
			issue_burst(BURST_BASE + 32'h40 * i, 3'(lengths[i]));
			drive_idle();
			if (last_waits == 0)
				fail_run("The burst request did not meet a memory stall cycle.");
			else
				drain_responses();
		end
	endtask

	task automatic run_back_to_back();
		test_name = "back to back";
		issue_burst(BURST_BASE + 32'h10, 3'd4);
		issue_read(addr_q[0]);
		issue_burst(BURST_BASE + 32'h20, 3'd7);
		issue_burst(BURST_BASE + 32'h44, 3'd2);
		issue_read(BURST_BASE);
		issue_burst(BURST_BASE + 32'h08, 3'd1);
		issue_read(addr_q[1]);
		drive_idle();
		drain_responses();
	endtask

	initial
	begin
		drive_idle();
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		run_single_rw();
		run_partial_writes();
		run_burst_lengths();
		run_stalled_bursts();
		run_back_to_back();
		// Any stray pulse would show up within the read latency.
		repeat (burst_pkg::READ_LATENCY + 4) @(posedge clk);
		test_name = "response count";
		check_value(words_requested, rdv_count);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
